// File: Makefile
TOP := tb_ex_stage

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -f files.f --top-module $(TOP) -o V$(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: ex_alu.sv
`default_nettype none

module ex_alu (
    input  ex_pkg::word_t               a,
    input  ex_pkg::word_t               b,
    input  logic [ex_pkg::ALU_OP_W-1:0] alu_op,
    output ex_pkg::word_t               result,
    output logic                        overflow
);
    import ex_pkg::*;

    word_t sum;
    word_t diff;
    logic  add_of;
    logic  sub_of;

    assign sum  = a + b;
    assign diff = a - b;

    // Signed overflow from the operand and result sign bits
    assign add_of = (a[DATA_W-1] == b[DATA_W-1]) && (sum[DATA_W-1] != a[DATA_W-1]);
    assign sub_of = (a[DATA_W-1] != b[DATA_W-1]) && (diff[DATA_W-1] != a[DATA_W-1]);

    //////////////////////////////////////////////////
    // Operation select
    //////////////////////////////////////////////////

    always_comb begin
        result   = sum;
        overflow = 1'b0;
        case (alu_op)
            ALU_ADD: begin
                result   = sum;
                overflow = add_of;
            end
            ALU_ADDU: result = sum;
            ALU_SUB: begin
                result   = diff;
                overflow = sub_of;
            end
            ALU_SUBU: result = diff;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);
            ALU_SLT:  result = {{(DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(DATA_W-1){1'b0}}, a < b};
            // Immediate sits in the low half of b
            ALU_LUI:  result = {b[15:0], 16'h0000};
            default:  result = sum;
        endcase
    end

endmodule

`default_nettype wire

// File: ex_decoder.sv
`default_nettype none

module ex_decoder (
    input  ex_pkg::instr_u                 instr,
    input  ex_pkg::word_t                  rs_data,
    input  ex_pkg::word_t                  rt_data,
    output ex_pkg::word_t                  alu_b,
    output logic [ex_pkg::ALU_OP_W-1:0]    alu_op,
    output logic [ex_pkg::REG_W-1:0]       shamt,
    output logic [ex_pkg::SH_OP_W-1:0]     sh_op,
    output logic [ex_pkg::RES_SEL_W-1:0]   res_sel,
    output logic [ex_pkg::REG_W-1:0]       dest,
    output logic                           of_disable,
    output logic                           is_movz,
    output logic                           is_movn,
    output logic                           legal
);
    import ex_pkg::*;

    word_t imm_sext;
    word_t imm_zext;

    assign imm_sext = {{(DATA_W-16){instr.i.imm[15]}}, instr.i.imm};
    assign imm_zext = {{(DATA_W-16){1'b0}}, instr.i.imm};

    always_comb begin
        // Defaults fit an R-type ALU instruction
        alu_b      = rt_data;
        alu_op     = ALU_ADDU;
        shamt      = instr.r.shamt;
        sh_op      = SH_SLL;
        res_sel    = RES_ALU;
        dest       = instr.r.rd;
        of_disable = 1'b0;
        is_movz    = 1'b0;
        is_movn    = 1'b0;
        legal      = 1'b1;

        if (instr.r.opcode == OP_SPECIAL) begin
            case (instr.r.funct)
                FN_ADD:  alu_op = ALU_ADD;
                FN_ADDU: alu_op = ALU_ADDU;
                FN_SUB:  alu_op = ALU_SUB;
                FN_SUBU: alu_op = ALU_SUBU;
                FN_AND:  alu_op = ALU_AND;
                FN_OR:   alu_op = ALU_OR;
                FN_XOR:  alu_op = ALU_XOR;
                FN_NOR:  alu_op = ALU_NOR;
                FN_SLT:  alu_op = ALU_SLT;
                FN_SLTU: alu_op = ALU_SLTU;
                FN_SLL, FN_SRL, FN_SRA: res_sel = RES_SHIFT;
                FN_SLLV, FN_SRLV, FN_SRAV: begin
                    res_sel = RES_SHIFT;
                    shamt   = rs_data[REG_W-1:0];
                end
                FN_MOVZ: is_movz = 1'b1;
                FN_MOVN: is_movn = 1'b1;
                default: legal = 1'b0;
            endcase
            of_disable = (instr.r.funct == FN_ADD) || (instr.r.funct == FN_SUB);
            if (instr.r.funct == FN_MOVZ || instr.r.funct == FN_MOVN) begin
                res_sel = RES_MOVE;
            end
            // Low two funct bits pick the shift kind
            case (instr.r.funct[1:0])
                2'b10:   sh_op = SH_SRL;
                2'b11:   sh_op = SH_SRA;
                default: sh_op = SH_SLL;
            endcase
        end else begin
            // I-type writes rt
            dest = instr.i.rt;
            case (instr.i.opcode)
                OP_ADDI: begin
                    alu_b      = imm_sext;
                    alu_op     = ALU_ADD;
                    of_disable = 1'b1;
                end
                OP_ADDIU: begin
                    alu_b  = imm_sext;
                    alu_op = ALU_ADDU;
                end
                OP_SLTI: begin
                    alu_b  = imm_sext;
                    alu_op = ALU_SLT;
                end
                OP_SLTIU: begin
                    alu_b  = imm_sext;
                    alu_op = ALU_SLTU;
                end
                OP_ANDI: begin
                    alu_b  = imm_zext;
                    alu_op = ALU_AND;
                end
                OP_ORI: begin
                    alu_b  = imm_zext;
                    alu_op = ALU_OR;
                end
                OP_XORI: begin
                    alu_b  = imm_zext;
                    alu_op = ALU_XOR;
                end
                OP_LUI: begin
                    alu_b  = imm_zext;
                    alu_op = ALU_LUI;
                end
                default: legal = 1'b0;
            endcase
        end
    end

    // The result selector relies on at most one move condition
    a_move_excl: assert final (!(is_movz && is_movn))
        else $error("ex_decoder: MOVZ and MOVN decoded together");

endmodule

`default_nettype wire

// File: ex_pkg.sv
`default_nettype none

package ex_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    localparam int DATA_W    = 32;
    localparam int REG_W     = 5;
    localparam int ALU_OP_W  = 4;
    localparam int SH_OP_W   = 2;
    localparam int RES_SEL_W = 2;

    typedef logic [DATA_W-1:0] word_t;

    //////////////////////////////////////////////////
    // Instruction word, R and I views
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [5:0]       opcode;
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rt;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] shamt;
        logic [5:0]       funct;
    } instr_r_t;

    typedef struct packed {
        logic [5:0]       opcode;
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rt;
        logic [15:0]      imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    // Opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // Function codes of SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_MOVZ = 6'h0a;
    localparam logic [5:0] FN_MOVN = 6'h0b;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // ALU operations
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_ADDU = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SUBU = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_NOR  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_LUI  = 4'd10;

    // Shifter operations
    localparam logic [SH_OP_W-1:0] SH_SLL = 2'd0;
    localparam logic [SH_OP_W-1:0] SH_SRL = 2'd1;
    localparam logic [SH_OP_W-1:0] SH_SRA = 2'd2;

    // Result sources
    localparam logic [RES_SEL_W-1:0] RES_ALU   = 2'd0;
    localparam logic [RES_SEL_W-1:0] RES_SHIFT = 2'd1;
    localparam logic [RES_SEL_W-1:0] RES_MOVE  = 2'd2;

endpackage

`default_nettype wire

// File: ex_result_sel.sv
`default_nettype none

module ex_result_sel (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           in_valid,
    input  logic [ex_pkg::RES_SEL_W-1:0]   res_sel,
    input  logic [ex_pkg::REG_W-1:0]       dest,
    input  logic                           of_disable,
    input  logic                           is_movz,
    input  logic                           is_movn,
    input  logic                           legal,
    input  ex_pkg::word_t                  alu_result,
    input  logic                           overflow,
    input  ex_pkg::word_t                  shift_result,
    input  ex_pkg::word_t                  rs_data,
    input  ex_pkg::word_t                  rt_data,
    output logic                           out_valid,
    output logic                           wr_en,
    output logic [ex_pkg::REG_W-1:0]       wr_addr,
    output ex_pkg::word_t                  wr_data
);
    import ex_pkg::*;

    word_t result;
    logic  rt_zero;
    logic  do_write;

    //////////////////////////////////////////////////
    // Result source and write rule
    //////////////////////////////////////////////////

    always_comb begin
        case (res_sel)
            RES_SHIFT: result = shift_result;
            RES_MOVE:  result = rs_data;
            default:   result = alu_result;
        endcase
    end

    assign rt_zero = (rt_data == '0);

    // Register 0 is never written
    assign do_write = legal
                   && (dest != '0)
                   && !(of_disable && overflow)
                   && !(is_movz && !rt_zero)
                   && !(is_movn && rt_zero);

    //////////////////////////////////////////////////
    // Write-back register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            wr_en     <= 1'b0;
            wr_addr   <= '0;
            wr_data   <= '0;
        end else begin
            out_valid <= in_valid;
            wr_en     <= in_valid && do_write;
            if (in_valid) begin
                wr_addr <= dest;
                wr_data <= result;
            end
        end
    end

    a_wr_en_valid: assert property (@(posedge clk) disable iff (!arst_n)
        wr_en |-> out_valid)
        else $error("ex_result_sel: wr_en without out_valid");

    a_wr_en_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
        wr_en |-> (wr_addr != '0))
        else $error("ex_result_sel: write to register 0");

endmodule

`default_nettype wire

// File: ex_shifter.sv
`default_nettype none

module ex_shifter (
    input  ex_pkg::word_t              data,
    input  logic [ex_pkg::REG_W-1:0]   amount,
    input  logic [ex_pkg::SH_OP_W-1:0] sh_op,
    output ex_pkg::word_t              result
);
    import ex_pkg::*;

    // One stage per amount bit, stage k shifts by 2**k
    word_t stage [REG_W+1];

    always_comb begin
        stage[0] = data;
        for (int k = 0; k < REG_W; k++) begin
            if (amount[k]) begin
                case (sh_op)
                    SH_SRL:  stage[k+1] = stage[k] >> (1 << k);
                    SH_SRA:  stage[k+1] = $unsigned($signed(stage[k]) >>> (1 << k));
                    default: stage[k+1] = stage[k] << (1 << k);
                endcase
            end else begin
                stage[k+1] = stage[k];
            end
        end
    end

    assign result = stage[REG_W];

endmodule

`default_nettype wire

// File: ex_stage.sv
`default_nettype none

module ex_stage (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,
    input  ex_pkg::instr_u           instr,
    input  ex_pkg::word_t            rs_data,
    input  ex_pkg::word_t            rt_data,
    output logic                     out_valid,
    output logic                     wr_en,
    output logic [ex_pkg::REG_W-1:0] wr_addr,
    output ex_pkg::word_t            wr_data
);
    import ex_pkg::*;

    // Decoder outputs
    word_t                alu_b;
    logic [ALU_OP_W-1:0]  alu_op;
    logic [REG_W-1:0]     shamt;
    logic [SH_OP_W-1:0]   sh_op;
    logic [RES_SEL_W-1:0] res_sel;
    logic [REG_W-1:0]     dest;
    logic                 of_disable;
    logic                 is_movz;
    logic                 is_movn;
    logic                 legal;

    // Datapath results
    word_t alu_result;
    logic  overflow;
    word_t shift_result;

    ex_decoder u_decoder (
        .instr      ( instr      ),
        .rs_data    ( rs_data    ),
        .rt_data    ( rt_data    ),
        .alu_b      ( alu_b      ),
        .alu_op     ( alu_op     ),
        .shamt      ( shamt      ),
        .sh_op      ( sh_op      ),
        .res_sel    ( res_sel    ),
        .dest       ( dest       ),
        .of_disable ( of_disable ),
        .is_movz    ( is_movz    ),
        .is_movn    ( is_movn    ),
        .legal      ( legal      )
    );

    ex_alu u_alu (
        .a        ( rs_data    ),
        .b        ( alu_b      ),
        .alu_op   ( alu_op     ),
        .result   ( alu_result ),
        .overflow ( overflow   )
    );

    ex_shifter u_shifter (
        .data   ( rt_data      ),
        .amount ( shamt        ),
        .sh_op  ( sh_op        ),
        .result ( shift_result )
    );

    ex_result_sel u_result_sel (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .in_valid     ( in_valid     ),
        .res_sel      ( res_sel      ),
        .dest         ( dest         ),
        .of_disable   ( of_disable   ),
        .is_movz      ( is_movz      ),
        .is_movn      ( is_movn      ),
        .legal        ( legal        ),
        .alu_result   ( alu_result   ),
        .overflow     ( overflow     ),
        .shift_result ( shift_result ),
        .rs_data      ( rs_data      ),
        .rt_data      ( rt_data      ),
        .out_valid    ( out_valid    ),
        .wr_en        ( wr_en        ),
        .wr_addr      ( wr_addr      ),
        .wr_data      ( wr_data      )
    );

endmodule

`default_nettype wire

// File: files.f
ex_pkg.sv
ex_decoder.sv
ex_alu.sv
ex_shifter.sv
ex_result_sel.sv
ex_stage.sv
tb_ex_stage.sv

// File: tb_ex_stage.sv
`default_nettype none

module tb_ex_stage;
    import ex_pkg::*;

    localparam int NUM_INSTR = 3000;
    // About one idle cycle in four, plus margin for reset and drain
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 4 / 3 + 200;

    localparam logic [5:0] R_FUNCTS [18] = '{
        FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT,
        FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_MOVZ, FN_MOVN
    };
    localparam logic [5:0] I_OPS [8] = '{
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI
    };

    typedef struct packed {
        logic             valid;
        logic             en;
        logic             known;
        logic [REG_W-1:0] addr;
        word_t            data;
    } expect_t;

    logic             clk;
    logic             arst_n;
    logic             in_valid;
    instr_u           instr;
    word_t            rs_data;
    word_t            rt_data;
    logic             out_valid;
    logic             wr_en;
    logic [REG_W-1:0] wr_addr;
    word_t            wr_data;

    // Expected outputs for the current cycle
    logic             exp_valid = 1'b0;
    logic             exp_en = 1'b0;
    logic             exp_known = 1'b0;
    logic [REG_W-1:0] exp_addr = '0;
    word_t            exp_data = '0;
    expect_t          exp_q [$];

    logic [31:0] lfsr_state = 32'h6620d4b2;
    int cycle_count = 0;
    int err_valid = 0;
    int err_en = 0;
    int err_addr = 0;
    int err_data = 0;

    ex_stage uut (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .in_valid  ( in_valid  ),
        .instr     ( instr     ),
        .rs_data   ( rs_data   ),
        .rt_data   ( rt_data   ),
        .out_valid ( out_valid ),
        .wr_en     ( wr_en     ),
        .wr_addr   ( wr_addr   ),
        .wr_data   ( wr_data   )
    );

    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // Random source
    //////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Zero and the signed extremes come up often
    task automatic pick_operand(output word_t v);
        logic [31:0] r;
        rand_bits(3, r);
        if (r[2:0] == 3'd0) begin
            v = '0;
        end else if (r[2:0] == 3'd1) begin
            rand_bits(1, r);
            v = r[0] ? 32'h7fffffff : 32'h80000000;
        end else begin
            rand_bits(32, v);
        end
    endtask

    task automatic build_instr(output logic [31:0] w);
        logic [31:0] r;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  rs_f;
        logic [4:0]  rt_f;
        logic [4:0]  rd_f;
        logic [4:0]  sh;
        logic [15:0] imm;
        int          idx;
        rand_bits(20, r);
        rs_f = r[4:0];
        rt_f = r[9:5];
        rd_f = r[14:10];
        sh   = r[19:15];
        rand_bits(16, r);
        imm = r[15:0];
        fn  = 6'h00;
        rand_bits(4, r);
        if (r[3:0] == 4'd0) begin
            rd_f = 5'd0;
            rt_f = 5'd0;
        end
        rand_bits(5, r);
        idx = int'(r % 32'd26);
        if (idx < 18) begin
            op = OP_SPECIAL;
            fn = R_FUNCTS[idx];
        end else begin
            op = I_OPS[idx-18];
        end
        // Unused opcodes and function codes
        rand_bits(4, r);
        if (r[3:0] == 4'd0) begin
            rand_bits(5, r);
            if (r[4]) begin
                op = {2'b01, r[3:0]};
            end else begin
                op = OP_SPECIAL;
                fn = {2'b11, r[3:0]};
            end
        end
        if (op == OP_SPECIAL) begin
            w = {op, rs_f, rt_f, rd_f, sh, fn};
        end else begin
            w = {op, rs_f, rt_f, imm};
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    task automatic predict(input logic [31:0] w, input word_t rs, input word_t rt,
                           output expect_t e);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  sh;
        logic [4:0]  dest;
        word_t       simm;
        word_t       zimm;
        word_t       res;
        logic [32:0] wide;
        logic        legal;
        logic        ovf;
        logic        cond;
        op    = w[31:26];
        fn    = w[5:0];
        sh    = w[10:6];
        simm  = {{16{w[15]}}, w[15:0]};
        zimm  = {16'h0000, w[15:0]};
        res   = '0;
        legal = 1'b1;
        ovf   = 1'b0;
        cond  = 1'b1;
        if (op == OP_SPECIAL) begin
            dest = w[15:11];
            case (fn)
                FN_ADD: begin
                    wide = {rs[31], rs} + {rt[31], rt};
                    res  = wide[31:0];
                    ovf  = wide[32] ^ wide[31];
                end
                FN_ADDU: res = rs + rt;
                FN_SUB: begin
                    wide = {rs[31], rs} - {rt[31], rt};
                    res  = wide[31:0];
                    ovf  = wide[32] ^ wide[31];
                end
                FN_SUBU: res = rs - rt;
                FN_AND:  res = rs & rt;
                FN_OR:   res = rs | rt;
                FN_XOR:  res = rs ^ rt;
                FN_NOR:  res = ~(rs | rt);
                FN_SLT:  res = {31'b0, $signed(rs) < $signed(rt)};
                FN_SLTU: res = {31'b0, rs < rt};
                FN_SLL:  res = rt << sh;
                FN_SRL:  res = rt >> sh;
                FN_SRA:  res = $signed(rt) >>> sh;
                FN_SLLV: res = rt << rs[4:0];
                FN_SRLV: res = rt >> rs[4:0];
                FN_SRAV: res = $signed(rt) >>> rs[4:0];
                FN_MOVZ: begin
                    res  = rs;
                    cond = (rt == '0);
                end
                FN_MOVN: begin
                    res  = rs;
                    cond = (rt != '0);
                end
                default: legal = 1'b0;
            endcase
        end else begin
            dest = w[20:16];
            case (op)
                OP_ADDI: begin
                    wide = {rs[31], rs} + {simm[31], simm};
                    res  = wide[31:0];
                    ovf  = wide[32] ^ wide[31];
                end
                OP_ADDIU: res = rs + simm;
                OP_SLTI:  res = {31'b0, $signed(rs) < $signed(simm)};
                OP_SLTIU: res = {31'b0, rs < simm};
                OP_ANDI:  res = rs & zimm;
                OP_ORI:   res = rs | zimm;
                OP_XORI:  res = rs ^ zimm;
                OP_LUI:   res = {w[15:0], 16'h0000};
                default:  legal = 1'b0;
            endcase
        end
        e.valid = 1'b1;
        e.known = legal;
        e.addr  = dest;
        e.data  = res;
        e.en    = legal && (dest != 5'd0) && !ovf && cond;
    endtask

    // Load this cycle's expectation, then drive the next instruction
    task automatic drive_cycle(input logic active);
        expect_t     e;
        logic [31:0] w;
        word_t       a;
        word_t       b;
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            exp_valid = e.valid;
            exp_en    = e.en;
            exp_known = e.known;
            exp_addr  = e.addr;
            exp_data  = e.data;
        end
        e = '0;
        if (active) begin
            build_instr(w);
            pick_operand(a);
            pick_operand(b);
            predict(w, a, b, e);
            instr   = w;
            rs_data = a;
            rt_data = b;
        end
        in_valid = active;
        exp_q.push_back(e);
    endtask

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    a_out_valid: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == exp_valid)
        else begin
            err_valid++;
            $display("CHECK FAILED t=%0t out_valid exp=%0b got=%0b",
                     $time, $sampled(exp_valid), $sampled(out_valid));
        end

    a_wr_en: assert property (@(posedge clk) disable iff (!arst_n)
        wr_en == exp_en)
        else begin
            err_en++;
            $display("CHECK FAILED t=%0t wr_en exp=%0b got=%0b",
                     $time, $sampled(exp_en), $sampled(wr_en));
        end

    // Address and data are only defined for legal instructions
    a_wr_addr: assert property (@(posedge clk) disable iff (!arst_n)
        (exp_valid && exp_known) |-> wr_addr == exp_addr)
        else begin
            err_addr++;
            $display("CHECK FAILED t=%0t wr_addr exp=%0d got=%0d",
                     $time, $sampled(exp_addr), $sampled(wr_addr));
        end

    a_wr_data: assert property (@(posedge clk) disable iff (!arst_n)
        (exp_valid && exp_known) |-> wr_data == exp_data)
        else begin
            err_data++;
            $display("CHECK FAILED t=%0t wr_data exp=%h got=%h",
                     $time, $sampled(exp_data), $sampled(wr_data));
        end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        logic        active;
        int          sent;
        int          total;
        clk      = 1'b0;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        instr    = '0;
        rs_data  = '0;
        rt_data  = '0;
        sent     = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        while (sent < NUM_INSTR) begin
            @(negedge clk);
            rand_bits(2, r);
            active = (r[1:0] != 2'b00);
            drive_cycle(active);
            if (active) begin
                sent++;
            end
        end
        // Drain the last result
        repeat (3) begin
            @(negedge clk);
            drive_cycle(1'b0);
        end

        total = err_valid + err_en + err_addr + err_data;
        $display("Errors: out_valid %0d, wr_en %0d, wr_addr %0d, wr_data %0d, total %0d",
                 err_valid, err_en, err_addr, err_data, total);
        if (total == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
